/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_bg_renderer
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/bg_defs.svh */
`ifndef BG_DEFS_SVH
`define BG_DEFS_SVH

// display line
`define BG_LINE_PIXELS 720

// tile geometry, 16x16 at 4 bpp, so four words per tile row
`define BG_TILE_PIXELS 16
`define BG_SPAN_TILES 46 // 736 buffer positions, line plus fine scroll

// tile map and tile sheet layout in words
`define BG_MAP_STRIDE 64
`define BG_SHEET_ROW_WORDS 1024
`define BG_PIXEL_ROW_WORDS 64

`define BG_TRANSPARENT_TILE 8'hFF

// register map, layer 0 then layer 1
`define BG_REG_CTRL0 4'd0
`define BG_REG_SCROLLX0 4'd1
`define BG_REG_SCROLLY0 4'd2
`define BG_REG_MAP0 4'd3
`define BG_REG_TILE0 4'd4
`define BG_REG_CTRL1 4'd5
`define BG_REG_SCROLLX1 4'd6
`define BG_REG_SCROLLY1 4'd7
`define BG_REG_MAP1 4'd8
`define BG_REG_TILE1 4'd9

`endif

/* design/bg_pkg.sv */
package bg_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [3:0] pixel_t;
	typedef logic [3:0] pal_t;
	typedef logic [7:0] color_t;
	typedef logic [9:0] line_x_t;
	typedef logic [7:0] buf_addr_t;

	// one layer's settings
	typedef struct packed {
		logic enable;
		pal_t pal_hi;
		word_t scroll_x;
		word_t scroll_y;
		word_t map_base;
		word_t tile_base;
	} layer_cfg_t;

	typedef struct packed {
		logic valid;
		word_t addr;
	} mem_req_t;

	typedef struct packed {
		logic we;
		buf_addr_t addr;
		word_t data;
	} buf_wr_t;

	typedef enum logic [2:0] {
		fs_idle,
		fs_map_read,
		fs_tile_decode,
		fs_data_read,
		fs_blank_write
	} fetch_state_e;

endpackage

/* design/bg_regs.sv */
`timescale 1ns/10ps
`include "bg_defs.svh"

module bg_regs (
	input logic CLK,
	input logic RSTb,
	input bg_pkg::reg_addr_t reg_addr,
	input bg_pkg::word_t reg_data,
	input logic reg_wr,
	output bg_pkg::layer_cfg_t cfg0,
	output bg_pkg::layer_cfg_t cfg1
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg0 <= '0;
			cfg1 <= '0; // both layers off
		end else if (reg_wr) begin
			case (reg_addr)
				`BG_REG_CTRL0: begin
					cfg0.enable <= reg_data[0];
					cfg0.pal_hi <= reg_data[7:4];
				end
				`BG_REG_SCROLLX0: begin
					cfg0.scroll_x <= reg_data;
				end
				`BG_REG_SCROLLY0: begin
					cfg0.scroll_y <= reg_data;
				end
				`BG_REG_MAP0: begin
					cfg0.map_base <= reg_data;
				end
				`BG_REG_TILE0: begin
					cfg0.tile_base <= reg_data;
				end
				// second layer
				`BG_REG_CTRL1: begin
					cfg1.enable <= reg_data[0];
					cfg1.pal_hi <= reg_data[7:4];
				end
				`BG_REG_SCROLLX1: begin
					cfg1.scroll_x <= reg_data;
				end
				`BG_REG_SCROLLY1: begin
					cfg1.scroll_y <= reg_data;
				end
				`BG_REG_MAP1: begin
					cfg1.map_base <= reg_data;
				end
				`BG_REG_TILE1: begin
					cfg1.tile_base <= reg_data;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* design/bg_renderer.sv */
`timescale 1ns/10ps

module bg_renderer (
	input logic CLK,
	input logic RSTb,
	input bg_pkg::reg_addr_t reg_addr,
	input bg_pkg::word_t reg_data,
	input logic reg_wr,
	input logic h_tick,
	input bg_pkg::line_x_t display_x,
	input bg_pkg::line_x_t display_y,
	output bg_pkg::color_t color_index,
	output bg_pkg::word_t memory_address,
	input bg_pkg::word_t memory_data,
	output logic rvalid,
	input logic rready
);

	bg_pkg::layer_cfg_t cfg0, cfg1;
	bg_pkg::mem_req_t req0, req1;
	logic ready0, ready1;
	bg_pkg::buf_wr_t wr0, wr1;
	bg_pkg::pixel_t pix0, pix1;
	bg_pkg::pal_t pal0_d1, pal0_d2;
	bg_pkg::pal_t pal1_d1, pal1_d2;

	bg_regs i_bg_regs (.CLK, .RSTb, .reg_addr, .reg_data, .reg_wr, .cfg0, .cfg1);

	layer_fetch i_fetch0 (.CLK, .RSTb, .h_tick, .display_y, .cfg(cfg0), .mem_req(req0),
		.mem_ready(ready0), .mem_data(memory_data), .buf_wr(wr0));

	layer_fetch i_fetch1 (.CLK, .RSTb, .h_tick, .display_y, .cfg(cfg1), .mem_req(req1),
		.mem_ready(ready1), .mem_data(memory_data), .buf_wr(wr1));

	mem_arbiter i_mem_arbiter (.CLK, .RSTb, .req0, .req1, .ready0, .ready1,
		.memory_address, .rvalid, .rready);

	scanline_buffer i_buf0 (.CLK, .RSTb, .h_tick, .cfg(cfg0), .buf_wr(wr0),
		.display_x, .pixel(pix0));

	scanline_buffer i_buf1 (.CLK, .RSTb, .h_tick, .cfg(cfg1), .buf_wr(wr1),
		.display_x, .pixel(pix1));

	// palettes follow the two-stage buffer read
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pal0_d1 <= '0;
			pal0_d2 <= '0;
			pal1_d1 <= '0;
			pal1_d2 <= '0;
		end else begin
			pal0_d1 <= cfg0.pal_hi;
			pal0_d2 <= pal0_d1;
			pal1_d1 <= cfg1.pal_hi;
			pal1_d2 <= pal1_d1;
		end
	end

	// layer 0 in front, zero pixel shows layer 1
	assign color_index = (pix0 != '0) ? {pal0_d2, pix0} : {pal1_d2, pix1};

endmodule

/* design/layer_fetch.sv */
`timescale 1ns/10ps
`include "bg_defs.svh"

module layer_fetch (
	input logic CLK,
	input logic RSTb,
	input logic h_tick,
	input bg_pkg::line_x_t display_y,
	input bg_pkg::layer_cfg_t cfg,
	output bg_pkg::mem_req_t mem_req,
	input logic mem_ready,
	input bg_pkg::word_t mem_data,
	output bg_pkg::buf_wr_t buf_wr
);

	bg_pkg::fetch_state_e state;

	logic [3:0] row; // pixel row inside the tile
	bg_pkg::word_t row_start;
	logic [16:0] map_index; // byte index into the tile map
	logic [16:0] map_index_start;
	logic [7:0] tile_code;
	logic [5:0] tile_num;
	logic [1:0] word_cnt;
	logic start;
	logic tile_done;
	logic last_tile;
	bg_pkg::word_t map_addr;
	bg_pkg::word_t tile_addr;

	assign start = h_tick && cfg.enable && (state == bg_pkg::fs_idle);
	assign row_start = cfg.scroll_y + bg_pkg::word_t'(display_y);
	assign map_index_start = 17'(row_start[15:4] * `BG_MAP_STRIDE) + 17'(cfg.scroll_x[15:4]);

	// two tile codes per map word
	assign map_addr = cfg.map_base + map_index[16:1];

	assign tile_addr = cfg.tile_base
		+ bg_pkg::word_t'(tile_code[7:4]) * bg_pkg::word_t'(`BG_SHEET_ROW_WORDS)
		+ bg_pkg::word_t'({tile_code[3:0], 2'b00})
		+ bg_pkg::word_t'(row) * bg_pkg::word_t'(`BG_PIXEL_ROW_WORDS)
		+ bg_pkg::word_t'(word_cnt);

	assign tile_done = buf_wr.we && (word_cnt == 2'd3);
	assign last_tile = (tile_num == 6'(`BG_SPAN_TILES - 1));

	always_comb begin
		mem_req.valid = (state == bg_pkg::fs_map_read) || (state == bg_pkg::fs_data_read);
		mem_req.addr = (state == bg_pkg::fs_map_read) ? map_addr : tile_addr;
	end

	always_comb begin
		buf_wr.we = (state == bg_pkg::fs_blank_write)
			|| ((state == bg_pkg::fs_data_read) && mem_ready);
		buf_wr.addr = {tile_num, word_cnt};
		buf_wr.data = (state == bg_pkg::fs_blank_write) ? '0 : mem_data;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= bg_pkg::fs_idle;
			tile_num <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				bg_pkg::fs_idle: begin
					if (start)
						state <= bg_pkg::fs_map_read;
				end
				bg_pkg::fs_map_read: begin
					if (mem_ready)
						state <= bg_pkg::fs_tile_decode;
				end
				bg_pkg::fs_tile_decode: begin
					if (tile_code == `BG_TRANSPARENT_TILE)
						state <= bg_pkg::fs_blank_write; // zeros without reads
					else
						state <= bg_pkg::fs_data_read;
				end
				bg_pkg::fs_data_read, bg_pkg::fs_blank_write: begin
					if (tile_done)
						state <= last_tile ? bg_pkg::fs_idle : bg_pkg::fs_map_read;
				end
				default: begin
					state <= bg_pkg::fs_idle;
				end
			endcase

			if (start)
				tile_num <= '0;
			else if (tile_done)
				tile_num <= tile_num + 6'd1;

			if (start)
				word_cnt <= '0;
			else if (buf_wr.we)
				word_cnt <= word_cnt + 2'd1; // wraps back to 0 per tile
		end
	end

	always_ff @(posedge CLK) begin
		if (start) begin
			row <= row_start[3:0];
			map_index <= map_index_start;
		end else if (tile_done) begin
			map_index <= map_index + 17'd1;
		end
		if ((state == bg_pkg::fs_map_read) && mem_ready)
			tile_code <= map_index[0] ? mem_data[15:8] : mem_data[7:0]; // odd index in high byte
	end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
	input logic CLK,
	input logic RSTb,
	input bg_pkg::mem_req_t req0,
	input bg_pkg::mem_req_t req1,
	output logic ready0,
	output logic ready1,
	output bg_pkg::word_t memory_address,
	output logic rvalid,
	input logic rready
);

	logic busy; // a request is waiting for rready
	logic owner; // current owner, or the last one served when not busy
	logic grant;

	// hold the owner while busy, else favour whoever was not served last
	always_comb begin
		if (busy)
			grant = owner;
		else if (req0.valid && req1.valid)
			grant = ~owner;
		else
			grant = req1.valid;
	end

	assign memory_address = grant ? req1.addr : req0.addr;
	assign rvalid = grant ? req1.valid : req0.valid;

	assign ready0 = rready && !grant;
	assign ready1 = rready && grant;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy <= 1'b0;
			owner <= 1'b1; // layer 0 goes first
		end else begin
			busy <= rvalid && !rready;
			if (rvalid)
				owner <= grant;
		end
	end

endmodule

/* design/scanline_buffer.sv */
`timescale 1ns/10ps
`include "bg_defs.svh"

module scanline_buffer (
	input logic CLK,
	input logic RSTb,
	input logic h_tick,
	input bg_pkg::layer_cfg_t cfg,
	input bg_pkg::buf_wr_t buf_wr,
	input bg_pkg::line_x_t display_x,
	output bg_pkg::pixel_t pixel
);

	bg_pkg::word_t line_mem [2][256];

	logic wr_half; // fetcher side, display reads the other one
	bg_pkg::line_x_t rd_pos;
	bg_pkg::word_t rd_word;
	logic [1:0] nib_sel;
	logic show;

	// fine scroll shifts the read position inside the buffer
	assign rd_pos = display_x + bg_pkg::line_x_t'(cfg.scroll_x % `BG_TILE_PIXELS);

	always_ff @(posedge CLK) begin
		if (!RSTb)
			wr_half <= 1'b0;
		else if (h_tick && cfg.enable)
			wr_half <= ~wr_half;
	end

	always_ff @(posedge CLK) begin
		if (buf_wr.we)
			line_mem[wr_half][buf_wr.addr] <= buf_wr.data;
	end

	// first stage, word read
	always_ff @(posedge CLK) begin
		rd_word <= line_mem[~wr_half][rd_pos[9:2]];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			nib_sel <= '0;
			show <= 1'b0;
		end else begin
			nib_sel <= rd_pos[1:0];
			show <= cfg.enable && (display_x < bg_pkg::line_x_t'(`BG_LINE_PIXELS));
		end
	end

	// second stage, nibble pick
	always_ff @(posedge CLK) begin
		if (!RSTb)
			pixel <= '0;
		else if (show)
			pixel <= rd_word[{nib_sel, 2'b00} +: 4]; // pixel 0 in the low nibble
		else
			pixel <= '0;
	end

endmodule

/* sim.f */
+incdir+design
design/bg_pkg.sv
design/bg_regs.sv
design/layer_fetch.sv
design/mem_arbiter.sv
design/scanline_buffer.sv
design/bg_renderer.sv
tests/tb_bg_renderer.sv

/* tests/tb_bg_renderer.sv */
`timescale 1ns/10ps
`include "bg_defs.svh"

module tb_bg_renderer;

	localparam int WAIT_CYCLES = 4000;
	localparam int TICKS = 17; // h_tick pulses over all tests
	localparam int SWEEPS = 9;
	localparam int WATCHDOG_CYCLES = 2 * (TICKS * (WAIT_CYCLES + 2)
		+ SWEEPS * (`BG_LINE_PIXELS + 2)) + 500;

	logic CLK = 1'b0;
	logic RSTb = 1'b0;
	bg_pkg::reg_addr_t reg_addr = '0;
	bg_pkg::word_t reg_data = '0;
	logic reg_wr = 1'b0;
	logic h_tick = 1'b0;
	bg_pkg::line_x_t display_x = '0;
	bg_pkg::line_x_t display_y = '0;
	bg_pkg::color_t color_index;
	bg_pkg::word_t memory_address;
	bg_pkg::word_t memory_data = '0;
	logic rvalid;
	logic rready = 1'b0;

	bg_pkg::word_t mem [65536];
	logic [31:0] seed = 32'hcf1c2baa;
	logic [31:0] lat_seed;
	logic [1:0] lat_left;
	logic armed = 1'b0;
	logic hold = 1'b0;
	bg_pkg::word_t hold_addr;

	// model copy of the layer registers, row is the map row of the fetched line
	logic en [2] = '{1'b0, 1'b0};
	logic [3:0] pal [2] = '{4'h0, 4'h0};
	int sx [2], sy [2], mbase [2], tbase [2], row [2];
	int errors = 0, checks = 0, requests = 0, mon_errors = 0;

	bg_renderer i_bg_renderer (.*);

	always #10 CLK = ~CLK;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] rand16();
		seed = lcg_next(seed);
		return seed[31:16];
	endfunction

	function automatic logic [3:0] model_pixel(input int l, input int x);
		int pos, idx, code, addr;
		bg_pkg::word_t w;
		if (!en[l])
			return 4'd0;
		pos = x + sx[l] % `BG_TILE_PIXELS; // fine scroll
		idx = (row[l] / 16) * `BG_MAP_STRIDE + sx[l] / 16 + pos / 16;
		w = mem[(mbase[l] + idx / 2) % 65536];
		code = idx % 2 ? w[15:8] : w[7:0];
		if (code == `BG_TRANSPARENT_TILE)
			return 4'd0;
		addr = tbase[l] + (code / 16) * `BG_SHEET_ROW_WORDS + (code % 16) * 4
			+ (row[l] % 16) * `BG_PIXEL_ROW_WORDS + (pos % 16) / 4;
		w = mem[addr % 65536];
		return w[(pos % 4) * 4 +: 4];
	endfunction

	function automatic logic [7:0] model_color(input int x);
		logic [3:0] p0, p1;
		p0 = model_pixel(0, x);
		p1 = model_pixel(1, x);
		return (p0 != 4'd0) ? {pal[0], p0} : {pal[1], p1};
	endfunction

	// map words of the line, or a tile row word in the sheet
	function automatic logic addr_expected(input int a);
		int map_first, off;
		for (int l = 0; l < 2; l++) begin
			if (en[l]) begin
				map_first = (mbase[l] + ((row[l] / 16) * 64 + sx[l] / 16) / 2) % 65536;
				off = (a - map_first + 65536) % 65536;
				if (off <= 23)
					return 1'b1;
				off = (a - (tbase[l] + (row[l] % 16) * 64) % 65536 + 65536) % 65536;
				if ((off & 16'hC3C0) == 0)
					return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// memory responder, rready after a random wait
	always @(posedge CLK) begin
		if (!RSTb) begin
			rready <= 1'b0;
			armed <= 1'b0;
		end else begin
			rready <= 1'b0;
			if (armed) begin
				if (lat_left == 2'd0) begin
					rready <= 1'b1;
					memory_data <= mem[memory_address];
					armed <= 1'b0;
				end else
					lat_left <= lat_left - 2'd1;
			end else if (rvalid && !rready) begin
				lat_seed = lcg_next(lat_seed);
				lat_left <= lat_seed[31:30];
				armed <= 1'b1;
			end
		end
	end

	always @(negedge CLK) begin
		if (RSTb && rvalid) begin
			if (hold) begin
				assert (memory_address == hold_addr) else begin
					$display("CHECK FAILED %0t: address moved from %h to %h before rready",
						$time, hold_addr, memory_address);
					errors++;
					mon_errors++;
				end
			end else begin
				requests++;
				assert (addr_expected(memory_address)) else begin
					$display("CHECK FAILED %0t: request to unexpected address %h",
						$time, memory_address);
					errors++;
					mon_errors++;
				end
			end
		end
		hold <= RSTb && rvalid && !rready;
		hold_addr <= memory_address;
	end

	task automatic write_reg(input bg_pkg::reg_addr_t a, input bg_pkg::word_t d);
		@(posedge CLK);
		reg_addr <= a;
		reg_data <= d;
		reg_wr <= 1'b1;
		@(posedge CLK);
		reg_wr <= 1'b0;
	endtask

	task automatic setup_layer(input int l, input logic on);
		bg_pkg::reg_addr_t b;
		bg_pkg::word_t w;
		b = l ? `BG_REG_CTRL1 : `BG_REG_CTRL0;
		w = rand16();
		pal[l] = w[7:4];
		en[l] = on;
		write_reg(b, {8'h00, w[7:4], 3'b000, on});
		sx[l] = rand16();
		write_reg(b + 4'd1, bg_pkg::word_t'(sx[l]));
		sy[l] = rand16();
		write_reg(b + 4'd2, bg_pkg::word_t'(sy[l]));
		mbase[l] = rand16();
		write_reg(b + 4'd3, bg_pkg::word_t'(mbase[l]));
		tbase[l] = rand16();
		write_reg(b + 4'd4, bg_pkg::word_t'(tbase[l]));
	endtask

	// overwrite every step-th tile code of line y with the transparent code
	task automatic blank_tiles(input int l, input int y, input int step);
		int idx, a;
		for (int t = 0; t < `BG_SPAN_TILES; t += step) begin
			idx = ((sy[l] + y) % 65536 / 16) * `BG_MAP_STRIDE + sx[l] / 16 + t;
			a = (mbase[l] + idx / 2) % 65536;
			if (idx % 2)
				mem[a][15:8] = `BG_TRANSPARENT_TILE;
			else
				mem[a][7:0] = `BG_TRANSPARENT_TILE;
		end
	endtask

	task automatic pulse_tick(input int y);
		@(posedge CLK);
		display_y <= bg_pkg::line_x_t'(y);
		h_tick <= 1'b1;
		@(posedge CLK);
		h_tick <= 1'b0;
	endtask

	task automatic sweep_line();
		logic [7:0] expected;
		for (int x = 0; x < `BG_LINE_PIXELS + 2; x++) begin
			@(posedge CLK);
			if (x < `BG_LINE_PIXELS)
				display_x <= bg_pkg::line_x_t'(x);
			@(negedge CLK);
			if (x >= 2) begin // two cycle read latency
				expected = model_color(x - 2);
				checks++;
				assert (color_index == expected) else begin
					$display("CHECK FAILED %0t: x=%0d color_index=%h expected %h",
						$time, x - 2, color_index, expected);
					errors++;
				end
			end
		end
	endtask

	// two ticks so both buffer halves hold line y
	task automatic run_line(input int y);
		for (int l = 0; l < 2; l++)
			row[l] = (sy[l] + y) % 65536;
		repeat (2) begin
			pulse_tick(y);
			repeat (WAIT_CYCLES) @(posedge CLK);
		end
		sweep_line();
	endtask

	task automatic report(input int num, input string name, input int e0, input int c0);
		$display("test %0d %s: %0d checks, %0d errors, %s", num, name, checks - c0,
			errors - e0, (errors == e0) ? "ok" : "FAILED");
	endtask

	initial begin
		int e0, c0, y;
		lat_seed = lcg_next(seed ^ 32'h5a5a5a5a);
		for (int a = 0; a < 65536; a++) begin
			seed = lcg_next(seed);
			mem[a] = seed[31:16] ^ bg_pkg::word_t'(a);
		end
		repeat (3) @(posedge CLK);
		RSTb <= 1'b1;

		e0 = errors;
		c0 = checks;
		pulse_tick(0);
		repeat (WAIT_CYCLES) begin
			@(negedge CLK);
			assert (rvalid == 1'b0) else begin
				$display("CHECK FAILED %0t: rvalid high with both layers disabled", $time);
				errors++;
			end
		end
		sweep_line();
		report(1, "reset state", e0, c0);

		e0 = errors;
		c0 = checks;
		setup_layer(0, 1'b1);
		setup_layer(1, 1'b0);
		repeat (4) begin
			y = rand16() % 480;
			run_line(y);
		end
		report(2, "layer 0 scrolling", e0, c0);

		e0 = errors;
		c0 = checks;
		y = rand16() % 480;
		run_line(y);
		blank_tiles(0, y, 3);
		run_line(y); // zeros over last line's data
		report(3, "transparent tiles", e0, c0);

		e0 = errors;
		c0 = checks;
		setup_layer(0, 1'b1);
		setup_layer(1, 1'b1);
		repeat (2) begin
			y = rand16() % 480;
			blank_tiles(0, y, 2);
			run_line(y);
		end
		report(4, "two layer merge", e0, c0);

		$display("test 5 memory handshake: %0d requests, %0d errors, %s", requests,
			mon_errors, (mon_errors == 0) ? "ok" : "FAILED");
		$display("done: %0d pixel checks, %0d requests, %0d errors", checks, requests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

endmodule
